//--- hdl/time_dmr_pkg.sv
package time_dmr_pkg;

    ////////////////////
    // Scalar types

    // One operand of the multiply-add
    typedef logic [15:0] operand_t;

    // Low 32 bits of a * b + c
    typedef logic [31:0] result_t;

    // Element ID, shared by both copies of one element, wraps modulo 4
    typedef logic [1:0] dmr_id_t;

    ////////////////////
    // Link payloads

    // Upstream request, the inject mask is only applied to the second copy
    typedef struct packed {
        operand_t a;
        operand_t b;
        operand_t c;
        result_t  inject;
    } mac_req_t;

    // Item entering the pipeline
    // Copy is 0 for the first issue and 1 for the replay
    // Redundant is high when a second copy of the same element follows
    typedef struct packed {
        dmr_id_t  id;
        logic     copy;
        logic     redundant;
        mac_req_t req;
    } pipe_item_t;

    // Item leaving the pipeline, tags unchanged and operands reduced to a result
    typedef struct packed {
        dmr_id_t id;
        logic    copy;
        logic    redundant;
        result_t result;
    } pipe_res_t;

    // Checked response towards downstream
    typedef struct packed {
        result_t result;
        dmr_id_t id;
        logic    needs_retry;
    } mac_rsp_t;

endpackage

//--- hdl/time_dmr_start.sv
module time_dmr_start (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    enable_i,

    // Upstream request link
    input  logic                    req_valid_i,
    input  time_dmr_pkg::mac_req_t  req_i,
    output logic                    req_ready_o,

    // Link into the shared pipeline
    output logic                    item_valid_o,
    output time_dmr_pkg::pipe_item_t item_o,
    input  logic                    item_ready_i
);

    // The held request is issued once as copy 0 and then replayed as copy 1
    typedef enum logic {
        issue_first,
        issue_second
    } issue_state_e;

    issue_state_e             state_q;
    logic                     valid_q;
    logic                     redundant_q;
    time_dmr_pkg::dmr_id_t    id_q;
    time_dmr_pkg::mac_req_t   req_q;

    logic req_fire;
    logic item_fire;
    logic last_copy;
    logic item_done;

    ////////////////////
    // Handshake

    // The current item is the last one of its element when it is the replay
    // or when the element was accepted without redundancy
    assign last_copy = (state_q == issue_second) || !redundant_q;

    assign item_fire = valid_q && item_ready_i;
    assign item_done = item_fire && last_copy;

    // A new request fits when nothing is held or the last copy leaves this cycle
    assign req_ready_o = !valid_q || item_done;
    assign req_fire    = req_valid_i && req_ready_o;

    ////////////////////
    // Issue state and ID

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q     <= 1'b0;
            state_q     <= issue_first;
            redundant_q <= 1'b0;
            id_q        <= '0;
        end else begin
            if (item_done) begin
                valid_q <= 1'b0;
                state_q <= issue_first;
                // One increment per element, so both copies share the ID
                id_q    <= id_q + time_dmr_pkg::dmr_id_t'(1);
            end else if (item_fire) begin
                // First copy of a redundant pair is gone, replay it next
                state_q <= issue_second;
            end
            // A request accepted in the same cycle as item_done overrides the clear
            if (req_fire) begin
                valid_q     <= 1'b1;
                state_q     <= issue_first;
                // enable_i is sampled per element so a pair is never split
                redundant_q <= enable_i;
            end
        end
    end

    // Request payload, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q <= req_i;
        end
    end

    ////////////////////
    // Item build

    always_comb begin
        item_o.id        = id_q;
        item_o.copy      = (state_q == issue_second);
        item_o.redundant = redundant_q;
        item_o.req       = req_q;
        // Only the replay carries the upset mask, copy 0 stays clean
        if (state_q == issue_first) begin
            item_o.req.inject = '0;
        end
    end

    assign item_valid_o = valid_q;

endmodule

//--- hdl/mac_pipeline.sv
module mac_pipeline #(
    // Number of register stages, at least 1
    parameter int pipe_depth = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    // Items from the issue side
    input  logic                     in_valid_i,
    input  time_dmr_pkg::pipe_item_t in_i,
    output logic                     in_ready_o,

    // Results towards the checker
    output logic                     out_valid_o,
    output time_dmr_pkg::pipe_res_t  out_o,
    input  logic                     out_ready_i
);

    time_dmr_pkg::pipe_res_t stage_q [pipe_depth];
    logic [pipe_depth-1:0]   valid_q;
    logic [pipe_depth:0]     stage_ready;

    time_dmr_pkg::result_t   mac_value;
    time_dmr_pkg::pipe_res_t first_stage;

    ////////////////////
    // Stage one datapath

    // Operands are widened first so the product keeps all 32 bits
    assign mac_value = time_dmr_pkg::result_t'(in_i.req.a) * time_dmr_pkg::result_t'(in_i.req.b)
                     + time_dmr_pkg::result_t'(in_i.req.c);

    always_comb begin
        first_stage.id        = in_i.id;
        first_stage.copy      = in_i.copy;
        first_stage.redundant = in_i.redundant;
        // Models a transient upset on the result, mask is zero for copy 0
        first_stage.result    = mac_value ^ in_i.req.inject;
    end

    ////////////////////
    // Stall chain

    // A stage may load when it is empty or its content moves on this cycle
    // so bubbles collapse and only stages holding data stall
    assign stage_ready[pipe_depth] = out_ready_i;
    for (genvar s = 0; s < pipe_depth; s++) begin : gen_ready
        assign stage_ready[s] = !valid_q[s] || stage_ready[s+1];
    end

    assign in_ready_o = stage_ready[0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            if (stage_ready[0]) begin
                valid_q[0] <= in_valid_i;
            end
            for (int s = 1; s < pipe_depth; s++) begin
                if (stage_ready[s]) begin
                    valid_q[s] <= valid_q[s-1];
                end
            end
        end
    end

    // Payload registers move only when a valid item is shifted in
    always_ff @(posedge clk_i) begin
        if (stage_ready[0] && in_valid_i) begin
            stage_q[0] <= first_stage;
        end
        for (int s = 1; s < pipe_depth; s++) begin
            if (stage_ready[s] && valid_q[s-1]) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    assign out_valid_o = valid_q[pipe_depth-1];
    assign out_o       = stage_q[pipe_depth-1];

endmodule

//--- hdl/time_dmr_end.sv
module time_dmr_end (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    enable_i,

    // Results from the pipeline exit
    input  logic                    in_valid_i,
    input  time_dmr_pkg::pipe_res_t in_i,
    output logic                    in_ready_o,

    // Checked response towards downstream
    output logic                    rsp_valid_o,
    output time_dmr_pkg::mac_rsp_t  rsp_o,
    input  logic                    rsp_ready_i,

    // One cycle pulse per detected fault
    output logic                    fault_detected_o
);

    // Pairing state, wait_second means a copy 0 is held
    typedef enum logic {
        wait_first,
        wait_second
    } pair_state_e;

    pair_state_e state_q;
    pair_state_e state_d;

    // Held first copy
    time_dmr_pkg::result_t first_result_q;
    time_dmr_pkg::dmr_id_t first_id_q;

    // Response register
    time_dmr_pkg::mac_rsp_t rsp_q;
    time_dmr_pkg::mac_rsp_t rsp_d;
    logic                   rsp_valid_q;

    logic fault_q;
    logic fault_d;

    logic in_fire;
    logic load_first;
    logic load_rsp;
    logic checked;
    logic id_same;
    logic data_same;

    ////////////////////
    // Handshake

    // Input stalls only while a response is held that downstream does not take
    assign in_ready_o = !rsp_valid_q || rsp_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    // Items checked against a partner only in redundant mode
    assign checked = enable_i && in_i.redundant;

    ////////////////////
    // Comparison

    // Arriving copy against the held one, both ID and data must agree
    assign id_same   = (in_i.id == first_id_q);
    assign data_same = (in_i.result == first_result_q);

    ////////////////////
    // Pairing FSM

    always_comb begin
        state_d    = state_q;
        load_first = 1'b0;
        load_rsp   = 1'b0;
        fault_d    = 1'b0;

        // Default response is the arriving item itself, no retry
        rsp_d.result      = in_i.result;
        rsp_d.id          = in_i.id;
        rsp_d.needs_retry = 1'b0;

        if (in_fire) begin
            if (!checked) begin
                // Bypass, forward untouched and drop any half pair
                load_rsp = 1'b1;
                state_d  = wait_first;
            end else begin
                case (state_q)
                    wait_first: begin
                        if (!in_i.copy) begin
                            load_first = 1'b1;
                            state_d    = wait_second;
                        end else begin
                            // Replay without a first copy, a sequence fault
                            // Its result cannot be trusted so downstream retries
                            load_rsp          = 1'b1;
                            rsp_d.needs_retry = 1'b1;
                            fault_d           = 1'b1;
                        end
                    end
                    wait_second: begin
                        // The held copy is reported in both branches
                        load_rsp     = 1'b1;
                        rsp_d.result = first_result_q;
                        rsp_d.id     = first_id_q;
                        if (in_i.copy) begin
                            state_d = wait_first;
                            if (!(id_same && data_same)) begin
                                rsp_d.needs_retry = 1'b1;
                                fault_d           = 1'b1;
                            end
                        end else begin
                            // Partner of the held copy never came
                            // The new copy 0 restarts the pairing
                            rsp_d.needs_retry = 1'b1;
                            fault_d           = 1'b1;
                            load_first        = 1'b1;
                        end
                    end
                    default: begin
                        state_d = wait_first;
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Registers

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= wait_first;
            rsp_valid_q <= 1'b0;
            fault_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load_rsp) begin
                rsp_valid_q <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            // Pulse lines up with the first cycle of the faulty response
            fault_q <= fault_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_first) begin
            first_result_q <= in_i.result;
            first_id_q     <= in_i.id;
        end
        if (load_rsp) begin
            rsp_q <= rsp_d;
        end
    end

    assign rsp_valid_o      = rsp_valid_q;
    assign rsp_o            = rsp_q;
    assign fault_detected_o = fault_q;

endmodule

//--- hdl/time_dmr_top.sv
module time_dmr_top #(
    // Register stages in the multiply-add pipeline
    parameter int pipe_depth = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   enable_i,

    // Upstream requests
    input  logic                   req_valid_i,
    input  time_dmr_pkg::mac_req_t req_i,
    output logic                   req_ready_o,

    // Downstream responses
    output logic                   rsp_valid_o,
    output time_dmr_pkg::mac_rsp_t rsp_o,
    input  logic                   rsp_ready_i,

    // Fault pulse for error counting
    output logic                   fault_detected_o
);

    ////////////////////
    // Internal links

    // Issue side into the pipeline
    logic                     start_to_pipe_valid;
    logic                     start_to_pipe_ready;
    time_dmr_pkg::pipe_item_t start_to_pipe;

    // Pipeline exit into the checker
    logic                     pipe_to_end_valid;
    logic                     pipe_to_end_ready;
    time_dmr_pkg::pipe_res_t  pipe_to_end;

    // Tags and replays each request
    time_dmr_start start_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .enable_i     (enable_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .item_valid_o (start_to_pipe_valid),
        .item_o       (start_to_pipe),
        .item_ready_i (start_to_pipe_ready)
    );

    // Shared datapath, both copies pass through it in turn
    mac_pipeline #(
        .pipe_depth (pipe_depth)
    ) pipe_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_valid_i  (start_to_pipe_valid),
        .in_i        (start_to_pipe),
        .in_ready_o  (start_to_pipe_ready),
        .out_valid_o (pipe_to_end_valid),
        .out_o       (pipe_to_end),
        .out_ready_i (pipe_to_end_ready)
    );

    // Pairs copies and reports one checked response per element
    time_dmr_end end_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .enable_i         (enable_i),
        .in_valid_i       (pipe_to_end_valid),
        .in_i             (pipe_to_end),
        .in_ready_o       (pipe_to_end_ready),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o),
        .rsp_ready_i      (rsp_ready_i),
        .fault_detected_o (fault_detected_o)
    );

endmodule

//--- verif/time_dmr_properties.sv
module time_dmr_properties (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   rsp_valid_o,
    input time_dmr_pkg::mac_rsp_t rsp_o,
    input logic                   rsp_ready_i,
    input logic                   fault_detected_o
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // Output handshake

    // A response that downstream has not taken stays offered
    valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o)
        else $error("rsp_valid_o dropped before rsp_ready_i");

    // The payload must not change while the response waits
    payload_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        rsp_valid_o && !rsp_ready_i |=> $stable(rsp_o))
        else $error("rsp_o changed while the response was stalled");

    ////////////////////
    // Fault pulse

    // Pulse is a single cycle per detected fault
    fault_single: assert property (@(posedge clk_i) disable iff (rst_i)
        fault_detected_o |=> !fault_detected_o)
        else $error("fault_detected_o high for two consecutive cycles");

    ////////////////////
    // Reset

    // Response register comes out of reset empty
    reset_empty: assert property (@(posedge clk_i)
        rst_i |=> !rsp_valid_o)
        else $error("rsp_valid_o high in the cycle after reset");

endmodule

//--- verif/time_dmr_tb.sv
module time_dmr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int pipe_depth     = 3;
    localparam int timeout_cycles = 200;
    localparam int total_reqs     = 93;

    logic                   clk;
    logic                   rst;
    logic                   enable;
    logic                   req_valid;
    time_dmr_pkg::mac_req_t req;
    logic                   req_ready;
    logic                   rsp_valid;
    time_dmr_pkg::mac_rsp_t rsp;
    logic                   rsp_ready;
    logic                   fault_detected;

    // Stimulus is drawn once at time zero, back-pressure draws during the run
    integer                 seed = 32'he608_4450;
    time_dmr_pkg::mac_req_t stim [total_reqs];

    // Reference model state, one expected response per accepted request
    time_dmr_pkg::mac_rsp_t exp_q [$];
    time_dmr_pkg::dmr_id_t  model_id;
    int                     expected_faults;
    int                     fault_count;
    int                     value_errors;
    int                     other_errors;
    logic                   bp_on;

    time_dmr_top #(
        .pipe_depth (pipe_depth)
    ) dut_i (
        .clk_i            (clk),
        .rst_i            (rst),
        .enable_i         (enable),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .req_ready_o      (req_ready),
        .rsp_valid_o      (rsp_valid),
        .rsp_o            (rsp),
        .rsp_ready_i      (rsp_ready),
        .fault_detected_o (fault_detected)
    );

    // Output protocol checks sit on the checker itself
    bind time_dmr_end time_dmr_properties props_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_o            (rsp_o),
        .rsp_ready_i      (rsp_ready_i),
        .fault_detected_o (fault_detected_o)
    );

    always #5 clk = ~clk;

    ////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: actual 0x%h, expected 0x%h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // Mask mode 0 leaves every request clean, 1 upsets every other one,
    // 2 upsets about a third and 3 upsets all of them
    task automatic fill_requests(input int first, input int count, input int mask_mode);
        time_dmr_pkg::mac_req_t r;
        logic [31:0]            upset;
        logic                   use_mask;
        for (int i = first; i < first + count; i++) begin
            r.a   = $random(seed);
            r.b   = $random(seed);
            r.c   = $random(seed);
            upset = $random(seed);
            // A zero mask would hide the upset
            if (upset == '0) begin
                upset = 32'h1;
            end
            case (mask_mode)
                1:       use_mask = (i % 2 == 1);
                2:       use_mask = ({$random(seed)} % 100) < 30;
                3:       use_mask = 1'b1;
                default: use_mask = 1'b0;
            endcase
            r.inject = use_mask ? upset : '0;
            stim[i]  = r;
        end
    endtask

    // Expected response follows from the operands, the mask and the mode
    task automatic record_expected(input time_dmr_pkg::mac_req_t r);
        time_dmr_pkg::mac_rsp_t e;
        logic [31:0]            product;
        product       = {16'h0, r.a} * {16'h0, r.b};
        e.result      = product + {16'h0, r.c};
        e.id          = model_id;
        // Only a compared pair can reveal the upset of the replay
        e.needs_retry = enable && (r.inject != '0);
        if (e.needs_retry) begin
            expected_faults++;
        end
        exp_q.push_back(e);
        model_id = model_id + 2'd1;
    endtask

    // Offers one request and returns 1 ns after the edge that took it
    task automatic send_request(input time_dmr_pkg::mac_req_t r);
        int   waited;
        logic taken;
        waited    = 0;
        taken     = 1'b0;
        req_valid = 1'b1;
        req       = r;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited > timeout_cycles) begin
                $display("Timeout: request not accepted within %0d cycles", timeout_cycles);
                other_errors++;
                finish_run();
            end
        end
        record_expected(r);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > timeout_cycles) begin
                $display("Timeout: %0d responses still missing after %0d cycles",
                         exp_q.size(), timeout_cycles);
                other_errors++;
                finish_run();
            end
        end
    endtask

    // Requests stream back to back, then the phase drains completely
    task automatic run_phase(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            send_request(stim[i]);
        end
        req_valid = 1'b0;
        wait_drained();
        check_value("fault_detected_o pulses", fault_count, expected_faults);
    endtask

    ////////////////////
    // Response monitor

    // Sampled mid cycle, where handshake and payload are settled
    always @(negedge clk) begin : monitor
        time_dmr_pkg::mac_rsp_t e;
        if (!rst) begin
            if (fault_detected) begin
                fault_count++;
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected response while no request was outstanding");
                    other_errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value("rsp_o.result", rsp.result, e.result);
                    check_value("rsp_o.id", {30'h0, rsp.id}, {30'h0, e.id});
                    check_value("rsp_o.needs_retry", {31'h0, rsp.needs_retry},
                                {31'h0, e.needs_retry});
                end
            end
        end
    end

    // Downstream ready, about 40 percent low while back-pressure is on
    always begin
        @(posedge clk);
        #1;
        if (bp_on) begin
            rsp_ready = ({$random(seed)} % 100) >= 40;
        end else begin
            rsp_ready = 1'b1;
        end
    end

    ////////////////////
    // Main sequence

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        enable          = 1'b1;
        req_valid       = 1'b0;
        req             = '0;
        rsp_ready       = 1'b1;
        bp_on           = 1'b0;
        model_id        = '0;
        expected_faults = 0;
        fault_count     = 0;
        value_errors    = 0;
        other_errors    = 0;

        fill_requests(0, 12, 0);
        fill_requests(12, 16, 1);
        fill_requests(28, 40, 2);
        fill_requests(68, 16, 3);
        fill_requests(84, 9, 0);

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // Clean pairs, results must be exact
        run_phase(0, 12);
        // Upset replays, the clean first copy is reported with a retry
        run_phase(12, 16);

        // Continuous stream against a stalling sink
        @(negedge clk);
        bp_on = 1'b1;
        @(posedge clk);
        #1;
        run_phase(28, 40);
        @(negedge clk);
        bp_on = 1'b0;
        @(posedge clk);
        #1;

        // Single pass, every mask is set yet nothing gets flagged
        enable = 1'b0;
        run_phase(68, 16);
        enable = 1'b1;

        // More than four elements in a row walk the ID through its wrap
        run_phase(84, 9);

        finish_run();
    end

endmodule

//--- time_dmr.f
hdl/time_dmr_pkg.sv
hdl/time_dmr_start.sv
hdl/mac_pipeline.sv
hdl/time_dmr_end.sv
hdl/time_dmr_top.sv
verif/time_dmr_properties.sv
verif/time_dmr_tb.sv

//--- Bender.yml
package:
  name: time_dmr

sources:
  # Shared types come first, then the blocks, then the top level
  - files:
      - hdl/time_dmr_pkg.sv
      - hdl/time_dmr_start.sv
      - hdl/mac_pipeline.sv
      - hdl/time_dmr_end.sv
      - hdl/time_dmr_top.sv

  # Simulation only sources
  - target: test
    files:
      - verif/time_dmr_properties.sv
      - verif/time_dmr_tb.sv
